//--- Makefile
# Verilator simulation of the P4 router egress

SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = p4_router_egress_tb
FILELIST = p4_router_egress.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = All checks passed

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- logic/egress_bus_pkg.sv
// Wide egress bus widths and the bus word type
`default_nettype none

package egress_bus_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Bus geometry

    // Bytes per wide bus word
    localparam int DATA_BYTES = 8;
    localparam int DATA_W     = DATA_BYTES * 8;

    // One byte enable per byte lane
    localparam int KEEP_W = DATA_BYTES;

    ////////////////////////////////////////////////////////////////////////////
    // Bus word

    // Whole beat for storage and steering, byte lanes for the narrow ports.
    // Lane 0 sits in the low bits and goes out first.
    typedef union packed {
        logic [DATA_W-1:0]          word;
        logic [DATA_BYTES-1:0][7:0] bytes;
    } egr_word_u;

endpackage

`default_nettype wire

//--- logic/egress_cfg_pkg.sv
// Egress port counts, port number map, buffer sizing and MTU
`default_nettype none

package egress_cfg_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Port groups

    localparam int NUM_8B_PORTS  = 2;
    localparam int NUM_16B_PORTS = 2;
    localparam int NUM_PORTS     = NUM_8B_PORTS + NUM_16B_PORTS;

    // Destination port number width
    localparam int PORT_SEL_W = $clog2(NUM_PORTS);

    // Port numbers run 8-bit group first, then 16-bit group
    localparam int INDEX_8B_START  = 0;
    localparam int INDEX_16B_START = INDEX_8B_START + NUM_8B_PORTS;

    ////////////////////////////////////////////////////////////////////////////
    // Buffering

    // Per-port buffer depth in bus words
    localparam int BUF_DEPTH = 32;
    // Fill count must reach BUF_DEPTH itself
    localparam int BUF_CNT_W = $clog2(BUF_DEPTH + 1);

    // Largest packet, in bytes and in bus words (needs the bus package first)
    localparam int MTU_BYTES = 64;
    localparam int MTU_WORDS = MTU_BYTES / egress_bus_pkg::DATA_BYTES;

endpackage

`default_nettype wire

//--- logic/egress_port_buffer.sv
// Per-port show-ahead FIFO of bus words with keep, last and fill level
`default_nettype none

module egress_port_buffer (
    input  wire logic                              clk,
    input  wire logic                              rst_n,
    input  wire logic                              wr,
    input  wire egress_bus_pkg::egr_word_u         wr_data,
    input  wire logic [egress_bus_pkg::KEEP_W-1:0] wr_keep,
    input  wire logic                              wr_last,
    input  wire logic                              rd_pop,
    output logic                                   rd_valid,
    output egress_bus_pkg::egr_word_u              rd_data,
    output logic [egress_bus_pkg::KEEP_W-1:0]      rd_keep,
    output logic                                   rd_last,
    output logic [egress_cfg_pkg::BUF_CNT_W-1:0]   count
);

    localparam int PTR_W = $clog2(egress_cfg_pkg::BUF_DEPTH);

    egress_bus_pkg::egr_word_u         data_mem [egress_cfg_pkg::BUF_DEPTH];
    logic [egress_bus_pkg::KEEP_W-1:0] keep_mem [egress_cfg_pkg::BUF_DEPTH];
    logic                              last_mem [egress_cfg_pkg::BUF_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;

    // Storage
    always_ff @(posedge clk) begin
        if (wr) begin
            data_mem[wr_ptr] <= wr_data;
            keep_mem[wr_ptr] <= wr_keep;
            last_mem[wr_ptr] <= wr_last;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr, rd_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head word shows ahead of the pop
    assign rd_valid = count != '0;
    assign rd_data  = data_mem[rd_ptr];
    assign rd_keep  = keep_mem[rd_ptr];
    assign rd_last  = last_mem[rd_ptr];

    a_no_overrun: assert property (@(posedge clk) disable iff (!rst_n)
        wr |-> count != egress_cfg_pkg::BUF_CNT_W'(egress_cfg_pkg::BUF_DEPTH))
        else $error("write into full port buffer");

    a_no_underrun: assert property (@(posedge clk) disable iff (!rst_n)
        rd_pop |-> count != '0)
        else $error("pop from empty port buffer");

endmodule

`default_nettype wire

//--- logic/egress_steer.sv
// Egress input side: destination decode, per-packet drop decision,
// registered writes into the port buffers
`default_nettype none

module egress_steer (
    input  wire logic                              clk,
    input  wire logic                              rst_n,
    input  wire logic                              egr_valid,
    input  wire egress_bus_pkg::egr_word_u         egr_data,
    input  wire logic [egress_bus_pkg::KEEP_W-1:0] egr_keep,
    input  wire logic                              egr_last,
    input  wire logic [egress_cfg_pkg::PORT_SEL_W-1:0] egr_port,
    input  wire logic [egress_cfg_pkg::NUM_PORTS-1:0][egress_cfg_pkg::BUF_CNT_W-1:0] buf_count,
    output logic [egress_cfg_pkg::NUM_PORTS-1:0]   buf_wr,
    output egress_bus_pkg::egr_word_u              wr_data,
    output logic [egress_bus_pkg::KEEP_W-1:0]      wr_keep,
    output logic                                   wr_last,
    output logic [egress_cfg_pkg::NUM_PORTS-1:0]   buf_overflow
);

    localparam int BEAT_CNT_W = $clog2(egress_cfg_pkg::MTU_WORDS + 1);

    logic                                  in_pkt;
    logic                                  first_beat;
    logic [egress_cfg_pkg::PORT_SEL_W-1:0] dst_q;
    logic [egress_cfg_pkg::PORT_SEL_W-1:0] cur_port;
    logic                                  accept_q;
    logic                                  accept_now;
    logic                                  cur_accept;
    logic [egress_cfg_pkg::BUF_CNT_W-1:0]  dst_occ;
    logic [BEAT_CNT_W-1:0]                 beat_cnt;

    ////////////////////////////////////////////////////////////////////////////
    // Drop decision

    always_comb begin
        first_beat = egr_valid && !in_pkt;
        // A write still in flight to that buffer is not in its count yet
        dst_occ    = buf_count[egr_port]
                   + egress_cfg_pkg::BUF_CNT_W'(buf_wr[egr_port]);
        accept_now = dst_occ <= egress_cfg_pkg::BUF_CNT_W'(
                         egress_cfg_pkg::BUF_DEPTH - egress_cfg_pkg::MTU_WORDS);
        // Later beats follow what the first beat decided
        cur_port   = first_beat ? egr_port : dst_q;
        cur_accept = first_beat ? accept_now : accept_q;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_pkt       <= 1'b0;
            dst_q        <= '0;
            accept_q     <= 1'b0;
            beat_cnt     <= '0;
            buf_wr       <= '0;
            buf_overflow <= '0;
        end else begin
            buf_wr       <= '0;
            buf_overflow <= '0;
            if (egr_valid) begin
                in_pkt   <= !egr_last;
                beat_cnt <= egr_last ? '0 : beat_cnt + 1'b1;
                if (cur_accept) begin
                    buf_wr[cur_port] <= 1'b1;
                end
            end
            if (first_beat) begin
                dst_q                  <= egr_port;
                accept_q               <= accept_now;
                buf_overflow[egr_port] <= !accept_now;
            end
        end
    end

    // Shared write payload
    always_ff @(posedge clk) begin
        if (egr_valid) begin
            wr_data <= egr_data;
            wr_keep <= egr_keep;
            wr_last <= egr_last;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Input bus rules

    a_keep_contig: assert property (@(posedge clk) disable iff (!rst_n)
        egr_valid |-> (egr_keep != '0) && ((egr_keep & (egr_keep + 1'b1)) == '0))
        else $error("egr_keep not contiguous from byte 0");

    a_keep_partial_last: assert property (@(posedge clk) disable iff (!rst_n)
        egr_valid && !egr_last |-> &egr_keep)
        else $error("partial egr_keep before last beat");

    a_pkt_len: assert property (@(posedge clk) disable iff (!rst_n)
        egr_valid |-> beat_cnt < BEAT_CNT_W'(egress_cfg_pkg::MTU_WORDS))
        else $error("packet longer than MTU");

endmodule

`default_nettype wire

//--- logic/egress_width_adapt.sv
// Egress output side: splits one bus word into narrow port beats,
// low byte lanes first, with keep and last on the final beat
`default_nettype none

module egress_width_adapt #(
    parameter int OUT_BYTES = 1
) (
    input  wire logic                              clk,
    input  wire logic                              rst_n,
    input  wire logic                              rd_valid,
    input  wire egress_bus_pkg::egr_word_u         rd_data,
    input  wire logic [egress_bus_pkg::KEEP_W-1:0] rd_keep,
    input  wire logic                              rd_last,
    input  wire logic                              port_ready,
    output logic                                   rd_pop,
    output logic                                   port_valid,
    output logic [8*OUT_BYTES-1:0]                 port_data,
    output logic [OUT_BYTES-1:0]                   port_keep,
    output logic                                   port_last
);

    localparam int OUT_W      = 8 * OUT_BYTES;
    localparam int BYTE_CNT_W = $clog2(egress_bus_pkg::DATA_BYTES + 1);

    egress_bus_pkg::egr_word_u sh_word;
    logic [BYTE_CNT_W-1:0]     bytes_left;
    logic                      word_last;
    logic                      final_beat;
    logic                      slot_free;
    logic                      load;
    logic                      shift;

    ////////////////////////////////////////////////////////////////////////////
    // Beat control

    always_comb begin
        final_beat = bytes_left <= BYTE_CNT_W'(OUT_BYTES);
        // Free when idle or when the last beat of this word is leaving
        slot_free  = !port_valid || (port_ready && final_beat);
        load       = slot_free && rd_valid;
        shift      = port_valid && port_ready && !final_beat;
    end

    assign rd_pop = load;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            port_valid <= 1'b0;
            bytes_left <= '0;
        end else if (slot_free) begin
            port_valid <= rd_valid;
            if (rd_valid) begin
                bytes_left <= BYTE_CNT_W'($countones(rd_keep));
            end
        end else if (shift) begin
            bytes_left <= bytes_left - BYTE_CNT_W'(OUT_BYTES);
        end
    end

    // Shift register moves the next lanes down to lane 0
    always_ff @(posedge clk) begin
        if (load) begin
            sh_word   <= rd_data;
            word_last <= rd_last;
        end else if (shift) begin
            sh_word.word <= sh_word.word >> OUT_W;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Port beat

    always_comb begin
        for (int i = 0; i < OUT_BYTES; i++) begin
            port_data[8*i +: 8] = sh_word.bytes[i];
            // All ones except on a short final beat
            port_keep[i]        = bytes_left > BYTE_CNT_W'(i);
        end
        port_last = word_last && final_beat;
    end

    a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        port_valid && !port_ready |=> port_valid && $stable(port_data))
        else $error("port beat changed while stalled");

endmodule

`default_nettype wire

//--- logic/p4_router_egress.sv
// P4 router egress top: steer, then one buffer and one width adapter
// per 8-bit and 16-bit physical port
`default_nettype none

module p4_router_egress (
    input  wire logic                                  clk,
    input  wire logic                                  rst_n,
    input  wire logic                                  egr_valid,
    input  wire egress_bus_pkg::egr_word_u             egr_data,
    input  wire logic [egress_bus_pkg::KEEP_W-1:0]     egr_keep,
    input  wire logic                                  egr_last,
    input  wire logic [egress_cfg_pkg::PORT_SEL_W-1:0] egr_port,
    input  wire logic [egress_cfg_pkg::NUM_8B_PORTS-1:0]  egr_8b_ready,
    input  wire logic [egress_cfg_pkg::NUM_16B_PORTS-1:0] egr_16b_ready,
    output logic [egress_cfg_pkg::NUM_8B_PORTS-1:0]         egr_8b_valid,
    output logic [egress_cfg_pkg::NUM_8B_PORTS-1:0][7:0]    egr_8b_data,
    output logic [egress_cfg_pkg::NUM_8B_PORTS-1:0]         egr_8b_keep,
    output logic [egress_cfg_pkg::NUM_8B_PORTS-1:0]         egr_8b_last,
    output logic [egress_cfg_pkg::NUM_16B_PORTS-1:0]        egr_16b_valid,
    output logic [egress_cfg_pkg::NUM_16B_PORTS-1:0][15:0]  egr_16b_data,
    output logic [egress_cfg_pkg::NUM_16B_PORTS-1:0][1:0]   egr_16b_keep,
    output logic [egress_cfg_pkg::NUM_16B_PORTS-1:0]        egr_16b_last,
    output logic [egress_cfg_pkg::NUM_8B_PORTS-1:0]         egr_8b_buf_overflow,
    output logic [egress_cfg_pkg::NUM_16B_PORTS-1:0]        egr_16b_buf_overflow
);

    localparam int NP = egress_cfg_pkg::NUM_PORTS;

    logic [NP-1:0]                                  buf_wr;
    egress_bus_pkg::egr_word_u                      wr_data;
    logic [egress_bus_pkg::KEEP_W-1:0]              wr_keep;
    logic                                           wr_last;
    logic [NP-1:0][egress_cfg_pkg::BUF_CNT_W-1:0]   buf_count;
    logic [NP-1:0]                                  buf_overflow;
    logic [NP-1:0]                                  rd_valid;
    egress_bus_pkg::egr_word_u [NP-1:0]             rd_data;
    logic [NP-1:0][egress_bus_pkg::KEEP_W-1:0]      rd_keep;
    logic [NP-1:0]                                  rd_last;
    logic [NP-1:0]                                  rd_pop;

    egress_steer u_steer (
        .clk(clk), .rst_n(rst_n),
        .egr_valid(egr_valid), .egr_data(egr_data), .egr_keep(egr_keep),
        .egr_last(egr_last), .egr_port(egr_port), .buf_count(buf_count),
        .buf_wr(buf_wr), .wr_data(wr_data), .wr_keep(wr_keep),
        .wr_last(wr_last), .buf_overflow(buf_overflow)
    );

    assign egr_8b_buf_overflow  =
        buf_overflow[egress_cfg_pkg::INDEX_8B_START +: egress_cfg_pkg::NUM_8B_PORTS];
    assign egr_16b_buf_overflow =
        buf_overflow[egress_cfg_pkg::INDEX_16B_START +: egress_cfg_pkg::NUM_16B_PORTS];

    ////////////////////////////////////////////////////////////////////////////
    // Per-port buffer and adapter

    for (genvar i = 0; i < egress_cfg_pkg::NUM_8B_PORTS; i++) begin : g_port_8b
        localparam int P = egress_cfg_pkg::INDEX_8B_START + i;
        egress_port_buffer u_buf (
            .clk(clk), .rst_n(rst_n), .wr(buf_wr[P]), .wr_data(wr_data),
            .wr_keep(wr_keep), .wr_last(wr_last), .rd_pop(rd_pop[P]),
            .rd_valid(rd_valid[P]), .rd_data(rd_data[P]), .rd_keep(rd_keep[P]),
            .rd_last(rd_last[P]), .count(buf_count[P])
        );
        egress_width_adapt #(.OUT_BYTES(1)) u_adapt (
            .clk(clk), .rst_n(rst_n), .rd_valid(rd_valid[P]), .rd_data(rd_data[P]),
            .rd_keep(rd_keep[P]), .rd_last(rd_last[P]), .port_ready(egr_8b_ready[i]),
            .rd_pop(rd_pop[P]), .port_valid(egr_8b_valid[i]), .port_data(egr_8b_data[i]),
            .port_keep(egr_8b_keep[i]), .port_last(egr_8b_last[i])
        );
    end

    for (genvar i = 0; i < egress_cfg_pkg::NUM_16B_PORTS; i++) begin : g_port_16b
        localparam int P = egress_cfg_pkg::INDEX_16B_START + i;
        egress_port_buffer u_buf (
            .clk(clk), .rst_n(rst_n), .wr(buf_wr[P]), .wr_data(wr_data),
            .wr_keep(wr_keep), .wr_last(wr_last), .rd_pop(rd_pop[P]),
            .rd_valid(rd_valid[P]), .rd_data(rd_data[P]), .rd_keep(rd_keep[P]),
            .rd_last(rd_last[P]), .count(buf_count[P])
        );
        egress_width_adapt #(.OUT_BYTES(2)) u_adapt (
            .clk(clk), .rst_n(rst_n), .rd_valid(rd_valid[P]), .rd_data(rd_data[P]),
            .rd_keep(rd_keep[P]), .rd_last(rd_last[P]), .port_ready(egr_16b_ready[i]),
            .rd_pop(rd_pop[P]), .port_valid(egr_16b_valid[i]), .port_data(egr_16b_data[i]),
            .port_keep(egr_16b_keep[i]), .port_last(egr_16b_last[i])
        );
    end

endmodule

`default_nettype wire

//--- p4_router_egress.f
logic/egress_bus_pkg.sv
logic/egress_cfg_pkg.sv
logic/egress_steer.sv
logic/egress_port_buffer.sv
logic/egress_width_adapt.sv
logic/p4_router_egress.sv
sim/p4_router_egress_tb.sv

//--- sim/p4_router_egress_tb.sv
// P4 router egress testbench with random packets, a per-port byte model
// and framing, overflow and stall checks
`default_nettype none

module p4_router_egress_tb;

    localparam int NP         = egress_cfg_pkg::NUM_PORTS;
    localparam int N8         = egress_cfg_pkg::NUM_8B_PORTS;
    localparam int N16        = egress_cfg_pkg::NUM_16B_PORTS;
    localparam int I16        = egress_cfg_pkg::INDEX_16B_START;
    localparam int MTU        = egress_cfg_pkg::MTU_WORDS;
    localparam int DB         = egress_bus_pkg::DATA_BYTES;
    localparam int MAX_CYCLES = 4000;

    logic                                  clk;
    logic                                  rst_n;
    logic                                  egr_valid;
    egress_bus_pkg::egr_word_u             egr_data;
    logic [egress_bus_pkg::KEEP_W-1:0]     egr_keep;
    logic                                  egr_last;
    logic [egress_cfg_pkg::PORT_SEL_W-1:0] egr_port;
    logic [NP-1:0]                         ready;
    logic [N8-1:0]                         egr_8b_valid;
    logic [N8-1:0][7:0]                    egr_8b_data;
    logic [N8-1:0]                         egr_8b_keep;
    logic [N8-1:0]                         egr_8b_last;
    logic [N16-1:0]                        egr_16b_valid;
    logic [N16-1:0][15:0]                  egr_16b_data;
    logic [N16-1:0][1:0]                   egr_16b_keep;
    logic [N16-1:0]                        egr_16b_last;
    logic [N8-1:0]                         egr_8b_buf_overflow;
    logic [N16-1:0]                        egr_16b_buf_overflow;

    // Expected bytes per port with bit 8 marking a packet's final byte
    logic [8:0]    exp_q [NP][$];
    int            pkt_out [NP];
    int            exp_ovf [NP];
    int            ovf_seen [NP];
    integer        seed;
    int            cycles;
    logic          ready_rand;

    // Output sampling state
    logic [NP-1:0] mon_valid;
    logic [NP-1:0] mon_last;
    logic [NP-1:0] ovf_vec;
    logic [15:0]   mon_data [NP];
    logic [1:0]    mon_keep [NP];
    logic [NP-1:0] stalled;
    logic [15:0]   held_data [NP];
    logic [1:0]    held_keep [NP];
    logic [NP-1:0] held_last;

    p4_router_egress dut (
        .clk(clk), .rst_n(rst_n),
        .egr_valid(egr_valid), .egr_data(egr_data), .egr_keep(egr_keep),
        .egr_last(egr_last), .egr_port(egr_port),
        .egr_8b_ready(ready[N8-1:0]), .egr_16b_ready(ready[NP-1:N8]),
        .egr_8b_valid(egr_8b_valid), .egr_8b_data(egr_8b_data),
        .egr_8b_keep(egr_8b_keep), .egr_8b_last(egr_8b_last),
        .egr_16b_valid(egr_16b_valid), .egr_16b_data(egr_16b_data),
        .egr_16b_keep(egr_16b_keep), .egr_16b_last(egr_16b_last),
        .egr_8b_buf_overflow(egr_8b_buf_overflow),
        .egr_16b_buf_overflow(egr_16b_buf_overflow)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Checks failed");
            $fatal(1);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks and model

    task automatic check_equal(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got %0h, expected %0h", name, got, exp);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    // Checks one transferred beat of up to two bytes against the model
    task automatic take_beat(input int p, input logic [15:0] data,
                             input logic [1:0] keep, input logic last);
        logic [8:0] lo;
        logic [8:0] hi;
        logic [1:0] exp_keep;
        if (exp_q[p].size() == 0) begin
            $display("output beat on port %0d while no packet was expected", p);
            $display("Checks failed");
            $fatal(1);
        end
        lo       = exp_q[p].pop_front();
        hi       = 9'h000;
        exp_keep = 2'b01;
        // Only a packet's last word is short, so pairs never straddle packets
        if (p >= I16 && !lo[8]) begin
            hi       = exp_q[p].pop_front();
            exp_keep = 2'b11;
        end
        check_equal($sformatf("port%0d_data", p), data & {{8{exp_keep[1]}}, 8'hff},
                    {hi[7:0], lo[7:0]});
        check_equal($sformatf("port%0d_keep", p), keep, exp_keep);
        check_equal($sformatf("port%0d_last", p), last, exp_keep[1] ? hi[8] : lo[8]);
        if (last) begin
            pkt_out[p]--;
        end
    endtask

    always @(negedge clk) begin
        if (rst_n) begin
            mon_valid = {egr_16b_valid, egr_8b_valid};
            mon_last  = {egr_16b_last, egr_8b_last};
            ovf_vec   = {egr_16b_buf_overflow, egr_8b_buf_overflow};
            for (int p = 0; p < NP; p++) begin
                if (p < I16) begin
                    mon_data[p] = {8'h00, egr_8b_data[p]};
                    mon_keep[p] = {1'b0, egr_8b_keep[p]};
                end else begin
                    mon_data[p] = egr_16b_data[p-I16];
                    mon_keep[p] = egr_16b_keep[p-I16];
                end
                // A stalled beat must be offered again unchanged
                if (stalled[p]) begin
                    check_equal($sformatf("port%0d_valid", p), mon_valid[p], 1'b1);
                    check_equal($sformatf("port%0d_data", p), mon_data[p], held_data[p]);
                    check_equal($sformatf("port%0d_keep", p), mon_keep[p], held_keep[p]);
                    check_equal($sformatf("port%0d_last", p), mon_last[p], held_last[p]);
                end
                if (mon_valid[p] && ready[p]) begin
                    take_beat(p, mon_data[p], mon_keep[p], mon_last[p]);
                end
                if (ovf_vec[p]) begin
                    ovf_seen[p]++;
                end
                stalled[p]   = mon_valid[p] && !ready[p];
                held_data[p] = mon_data[p];
                held_keep[p] = mon_keep[p];
                held_last[p] = mon_last[p];
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus

    task automatic step();
        @(posedge clk);
        #1;
        if (ready_rand) begin
            ready = 4'($random(seed));
        end
    endtask

    task automatic idle();
        step();
        egr_valid = 1'b0;
        egr_last  = 1'b0;
    endtask

    task automatic send_packet(input int p, input int nwords, input int last_bytes,
                               input bit accept);
        int nb;
        if (accept) begin
            pkt_out[p]++;
        end else begin
            exp_ovf[p]++;
        end
        for (int w = 0; w < nwords; w++) begin
            step();
            nb            = (w == nwords - 1) ? last_bytes : DB;
            egr_valid     = 1'b1;
            egr_port      = 2'(p);
            egr_last      = (w == nwords - 1);
            egr_data.word = {$random(seed), $random(seed)};
            egr_keep      = 8'hff >> (DB - nb);
            if (accept) begin
                for (int b = 0; b < nb; b++) begin
                    exp_q[p].push_back({egr_last && (b == nb - 1), egr_data.bytes[b]});
                end
            end
        end
    endtask

    task automatic send_random_packet();
        int p;
        int nw;
        int lb;
        p  = int'($unsigned($random(seed)) % NP);
        nw = 1 + int'($unsigned($random(seed)) % MTU);
        lb = 1 + int'($unsigned($random(seed)) % DB);
        // Wait until at most one older packet is left so the buffer stays far below full
        while (pkt_out[p] > 1) begin
            idle();
        end
        send_packet(p, nw, lb, 1'b1);
        idle();
    endtask

    function automatic int outstanding();
        int sum;
        sum = 0;
        for (int p = 0; p < NP; p++) begin
            sum += pkt_out[p];
        end
        return sum;
    endfunction

    task automatic wait_drained();
        while (outstanding() != 0) begin
            idle();
        end
    endtask

    task automatic check_overflow_counts();
        for (int p = 0; p < NP; p++) begin
            check_equal($sformatf("buf_overflow[%0d] pulses", p), ovf_seen[p], exp_ovf[p]);
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        egr_valid  = 1'b0;
        egr_data   = '0;
        egr_keep   = '0;
        egr_last   = 1'b0;
        egr_port   = '0;
        ready      = '1;
        ready_rand = 1'b0;
        seed       = 8577;
        cycles     = 0;
        stalled    = '0;
        for (int p = 0; p < NP; p++) begin
            pkt_out[p]  = 0;
            exp_ovf[p]  = 0;
            ovf_seen[p] = 0;
        end
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Quiet outputs before any traffic
        repeat (3) begin
            @(negedge clk);
            check_equal("port_valid", {egr_16b_valid, egr_8b_valid}, '0);
            check_equal("buf_overflow", {egr_16b_buf_overflow, egr_8b_buf_overflow}, '0);
        end

        // Random traffic with every port ready
        repeat (40) send_random_packet();
        wait_drained();
        check_overflow_counts();

        // Stalled 16-bit port 1 takes four packets and drops the next two
        ready[I16+1] = 1'b0;
        for (int k = 0; k < 6; k++) begin
            send_packet(I16 + 1, MTU, DB, k < 4);
        end
        idle();
        while (ovf_seen[I16+1] < 2) begin
            idle();
        end
        ready = '1;
        wait_drained();
        check_overflow_counts();

        // Light traffic under random readies
        ready_rand = 1'b1;
        repeat (14) send_random_packet();
        wait_drained();
        ready_rand = 1'b0;
        ready      = '1;
        check_overflow_counts();

        // Nothing left in any buffer or adapter
        @(negedge clk);
        check_equal("port_valid after drain", {egr_16b_valid, egr_8b_valid}, '0);

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire
